// File: vlog.f
+incdir+verilog
+incdir+dv
verilog/recon_pkg.sv
verilog/stageLink_if.sv
verilog/fwdTransform.sv
verilog/quantizer.sv
verilog/invTransform.sv
verilog/reconstruct.sv
dv/reconstructTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= reconstructTb
RTL_TOP   ?= reconstruct
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing --assert

SOURCES := $(wildcard verilog/*.sv verilog/*.svh dv/*.sv dv/*.svh)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "Test passed" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/reconstructModel.svh
`ifndef RECONSTRUCT_MODEL_SVH
`define RECONSTRUCT_MODEL_SVH

// VP8 forward DCT of src - pred, pass 0 along rows, pass 1 down columns
function automatic coefBlock_t modelFdct(input pixBlock_t src, input pixBlock_t pred);
    int         cur [16];
    int         nxt [16];
    int         base;
    int         step;
    int         s0;
    int         s1;
    int         d0;
    int         d1;
    coefBlock_t res;
    for (int k = 0; k < 16; k++) begin
        cur[k] = int'(src[k]) - int'(pred[k]);
    end
    for (int pass = 0; pass < 2; pass++) begin
        for (int i = 0; i < 4; i++) begin
            base = (pass == 0) ? 4 * i : i;
            step = (pass == 0) ? 1 : 4;
            s0 = cur[base] + cur[base+3*step];
            s1 = cur[base+step] + cur[base+2*step];
            d0 = cur[base] - cur[base+3*step];
            d1 = cur[base+step] - cur[base+2*step];
            if (pass == 0) begin
                nxt[base]        = (s0 + s1) * 8;
                nxt[base+step]   = (d1 * 2217 + d0 * 5352 + 1812) >>> 9;
                nxt[base+2*step] = (s0 - s1) * 8;
                nxt[base+3*step] = (d0 * 2217 - d1 * 5352 + 937) >>> 9;
            end else begin
                nxt[base]        = (s0 + s1 + 7) >>> 4;
                nxt[base+step]   = ((d1 * 2217 + d0 * 5352 + 12000) >>> 16) + ((d0 != 0) ? 1 : 0);
                nxt[base+2*step] = (s0 - s1 + 7) >>> 4;
                nxt[base+3*step] = (d0 * 2217 - d1 * 5352 + 51000) >>> 16;
            end
        end
        cur = nxt;
    end
    for (int k = 0; k < 16; k++) begin
        res[k] = coef_t'(cur[k]);
    end
    return res;
endfunction

// One coefficient, sign handled apart from the magnitude
function automatic level_t modelQuant(input coef_t c, input quantSet_t s);
    longint mag;
    longint lvl;
    mag = (c < 0) ? -longint'(c) : longint'(c);
    lvl = (mag * longint'(s.iq) + longint'(s.bias)) >>> `RECON_QSHIFT;
    if (lvl > `RECON_MAX_LEVEL) begin
        lvl = `RECON_MAX_LEVEL;
    end
    return level_t'((c < 0) ? -lvl : lvl);
endfunction

function automatic levelBlock_t modelLevels(input pixBlock_t src, input pixBlock_t pred,
                                            input quantSet_t dc, input quantSet_t ac);
    coefBlock_t  coef;
    levelBlock_t lv;
    coef = modelFdct(src, pred);
    for (int k = 0; k < 16; k++) begin
        lv[k] = modelQuant(coef[k], (k == 0) ? dc : ac);
    end
    return lv;
endfunction

// Rotation constants of the VP8 inverse transform
function automatic longint rotA(input longint a);
    return ((a * 20091) >>> 16) + a;
endfunction

function automatic longint rotB(input longint a);
    return (a * 35468) >>> 16;
endfunction

// Dequantize, two transposing passes, add prediction, clamp to 0..255
function automatic pixBlock_t modelRecon(input levelBlock_t lv, input pixBlock_t pred,
                                         input quantSet_t dc, input quantSet_t ac);
    longint    cur [16];
    longint    nxt [16];
    longint    a;
    longint    b;
    longint    c;
    longint    d;
    longint    p;
    pixBlock_t res;
    for (int k = 0; k < 16; k++) begin
        cur[k] = longint'(lv[k]) * longint'((k == 0) ? dc.q : ac.q);
    end
    for (int pass = 0; pass < 2; pass++) begin
        for (int i = 0; i < 4; i++) begin
            // Rounding of the final shift rides on the second pass
            a = cur[i] + cur[8+i] + longint'(4 * pass);
            b = cur[i] - cur[8+i] + longint'(4 * pass);
            c = rotB(cur[4+i]) - rotA(cur[12+i]);
            d = rotA(cur[4+i]) + rotB(cur[12+i]);
            nxt[4*i]   = a + d;
            nxt[4*i+1] = b + c;
            nxt[4*i+2] = b - c;
            nxt[4*i+3] = a - d;
        end
        cur = nxt;
    end
    for (int k = 0; k < 16; k++) begin
        p = longint'(pred[k]) + (cur[k] >>> 3);
        res[k] = (p < 0) ? 8'd0 : ((p > 255) ? 8'd255 : 8'(p));
    end
    return res;
endfunction

`endif

// File: dv/reconstructTb.sv
`timescale 1ns/100ps
`default_nettype none
`include "recon_config.svh"

module reconstructTb
    import recon_pkg::*;
();

    localparam int  NumTests = 20;
    localparam time ClkPeriod = 100;
    localparam time DriveDelay = 5;
    localparam int  WatchdogCycles = NumTests * 20 + 20;
    localparam int  WithheldDelay = 25;
    // Stage slots between the input queue and the output
    localparam int  NumSlots = 3;

    localparam logic [1:0] KindRandom = 2'd0;
    localparam logic [1:0] KindEqual = 2'd1;
    localparam logic [1:0] KindExtreme = 2'd2;

    // Stimulus and expected response of one block
    typedef struct packed {
        logic [1:0]  kind;
        pixBlock_t   src;
        pixBlock_t   pred;
        quantSet_t   dcSet;
        quantSet_t   acSet;
        logic [7:0]  creditDelay;
        pixBlock_t   expRecon;
        levelBlock_t expLevels;
        logic        expNonZero;
    } testEntry_t;

    logic        clk;
    logic        rst_i;
    logic        blkValid_i;
    pixBlock_t   src_i;
    pixBlock_t   pred_i;
    quantSet_t   dcSet_i;
    quantSet_t   acSet_i;
    logic        outCredit_i;
    logic        credit_o;
    logic        outValid_o;
    pixBlock_t   recon_o;
    levelBlock_t levels_o;
    logic        nonZero_o;

    testEntry_t testTable [NumTests];
    int         inCredits;
    // Output credits the DUT holds by the receiver's count
    int         heldOut;
    int         sentCount;
    int         outCount;
    int         creditPulses;
    int         cycleCount;
    int         checkCount;
    int         errorCount;
    bit         firstSent;
    int         returnDue [$];

    `include "reconstructModel.svh"

    reconstruct UUT (
        .clk         (clk),
        .rst_i       (rst_i),
        .blkValid_i  (blkValid_i),
        .src_i       (src_i),
        .pred_i      (pred_i),
        .dcSet_i     (dcSet_i),
        .acSet_i     (acSet_i),
        .outCredit_i (outCredit_i),
        .credit_o    (credit_o),
        .outValid_o  (outValid_o),
        .recon_o     (recon_o),
        .levels_o    (levels_o),
        .nonZero_o   (nonZero_o)
    );

    always #(ClkPeriod / 2) clk = ~clk;

    // ----------------------------------------
    // Table construction
    // ----------------------------------------
    // iq is 2^17 / q and saturates at 16 bits for tiny q
    function automatic quantSet_t makeSet(input int q, input logic [31:0] bias);
        quantSet_t s;
        s.q    = 16'(q);
        s.iq   = (q < 3) ? 16'hffff : 16'((1 << `RECON_QSHIFT) / q);
        s.bias = bias;
        return s;
    endfunction

    function automatic quantSet_t randomSet();
        int q;
        q = $urandom_range(3, 100);
        return makeSet(q, 32'($urandom_range(0, 65535)));
    endfunction

    function automatic pixBlock_t randomBlock();
        pixBlock_t b;
        for (int k = 0; k < 16; k++) begin
            b[k] = 8'($urandom_range(0, 255));
        end
        return b;
    endfunction

    function automatic pixBlock_t flatBlock(input int value);
        return {16{8'(value)}};
    endfunction

    task automatic addEntry(input int n, input logic [1:0] kind, input pixBlock_t src,
                            input pixBlock_t pred, input quantSet_t dc, input quantSet_t ac,
                            input int delay);
        testEntry_t e;
        e.kind        = kind;
        e.src         = src;
        e.pred        = pred;
        e.dcSet       = dc;
        e.acSet       = ac;
        e.creditDelay = 8'(delay);
        e.expLevels   = modelLevels(src, pred, dc, ac);
        e.expNonZero  = (e.expLevels != '0);
        e.expRecon    = modelRecon(e.expLevels, pred, dc, ac);
        testTable[n]  = e;
    endtask

    task automatic buildTable();
        quantSet_t fixedDc;
        quantSet_t fixedAc;
        quantSet_t extSet;
        quantSet_t clipSet;
        quantSet_t heldDc;
        quantSet_t heldAc;
        pixBlock_t blk;
        fixedDc = makeSet(8, 32'd49152);
        fixedAc = makeSet(10, 32'd56320);
        extSet  = makeSet(1, 32'd0);
        // Bias alone pushes every level past the limit
        clipSet = makeSet(1, 32'h1000_0000);
        heldDc  = randomSet();
        heldAc  = randomSet();
        blk = randomBlock();
        addEntry(0, KindEqual, blk, blk, fixedDc, fixedAc, 0);
        addEntry(1, KindEqual, flatBlock(128), flatBlock(128), fixedDc, fixedAc, 0);
        for (int n = 2; n < 10; n++) begin
            addEntry(n, KindRandom, randomBlock(), randomBlock(), randomSet(), randomSet(),
                     $urandom_range(0, 3));
        end
        addEntry(10, KindExtreme, flatBlock(255), flatBlock(0), extSet, extSet, 0);
        addEntry(11, KindExtreme, flatBlock(0), flatBlock(255), extSet, extSet, 0);
        addEntry(12, KindExtreme, flatBlock(255), flatBlock(0), clipSet, clipSet, 0);
        // Slow credit return backs the whole pipeline up
        for (int n = 13; n < NumTests; n++) begin
            addEntry(n, KindRandom, randomBlock(), randomBlock(), heldDc, heldAc,
                     WithheldDelay);
        end
    endtask

    // ----------------------------------------
    // Checks on one output
    // ----------------------------------------
    task automatic checkOutput(input int n);
        testEntry_t e;
        e = testTable[n];
        for (int k = 0; k < 16; k++) begin
            checkCount += 3;
            if (levels_o[k] !== e.expLevels[k]) begin
                errorCount++;
                $display("error: block %0d levels_o[%0d] expected %h got %h",
                         n, k, e.expLevels[k], levels_o[k]);
            end
            if (levels_o[k] > `RECON_MAX_LEVEL || levels_o[k] < -`RECON_MAX_LEVEL) begin
                errorCount++;
                $display("error: block %0d levels_o[%0d] = %h is beyond the level limit",
                         n, k, levels_o[k]);
            end
            if (recon_o[k] !== e.expRecon[k]) begin
                errorCount++;
                $display("error: block %0d recon_o[%0d] expected %h got %h",
                         n, k, e.expRecon[k], recon_o[k]);
            end
        end
        checkCount++;
        if (nonZero_o !== e.expNonZero) begin
            errorCount++;
            $display("error: block %0d nonZero_o expected %h got %h",
                     n, e.expNonZero, nonZero_o);
        end
        // Zero residual gives zero levels and the prediction back
        if (e.kind == KindEqual) begin
            checkCount++;
            if (levels_o !== '0 || nonZero_o !== 1'b0 || recon_o !== e.pred) begin
                errorCount++;
                $display("error: block %0d recon_o expected %h got %h, nonZero_o %h",
                         n, e.pred, recon_o, nonZero_o);
            end
        end
    endtask

    // ----------------------------------------
    // Output monitor on the falling edge
    // ----------------------------------------
    always @(negedge clk) begin
        if (!rst_i) begin
            if (!firstSent && (outValid_o || credit_o)) begin
                errorCount++;
                $display("error: outValid_o %h credit_o %h before the first block",
                         outValid_o, credit_o);
            end
            if (credit_o) begin
                creditPulses++;
                inCredits++;
                if (creditPulses > sentCount) begin
                    errorCount++;
                    $display("credit_o pulsed while no block was waiting in the queue");
                end
            end
            if (outValid_o) begin
                if (heldOut <= 0) begin
                    errorCount++;
                    $display("Output block appeared while the DUT held no output credit");
                end
                if (outCount < NumTests) begin
                    checkOutput(outCount);
                    returnDue.push_back(cycleCount + 1 + int'(testTable[outCount].creditDelay));
                end else begin
                    errorCount++;
                    $display("More output blocks appeared than were sent");
                end
                heldOut--;
                outCount++;
            end
            if (outCredit_i) begin
                heldOut++;
            end
            if (sentCount - outCount > `RECON_IN_DEPTH + NumSlots) begin
                errorCount++;
                $display("More blocks in flight than the queue and the stage slots hold");
            end
        end
    end

    // Receiver hands back one credit per cycle once its delay has run out
    task automatic returnCredits();
        int slot;
        forever begin
            @(posedge clk);
            cycleCount++;
            #DriveDelay;
            slot = -1;
            foreach (returnDue[i]) begin
                if (slot < 0 && returnDue[i] <= cycleCount) begin
                    slot = i;
                end
            end
            outCredit_i = 1'b0;
            if (slot >= 0) begin
                returnDue.delete(slot);
                outCredit_i = 1'b1;
            end
        end
    endtask

    // Called and left a drive delay after a rising edge
    task automatic sendBlock(input int n);
        while (inCredits == 0) begin
            @(posedge clk);
            #DriveDelay;
        end
        blkValid_i = 1'b1;
        src_i      = testTable[n].src;
        pred_i     = testTable[n].pred;
        inCredits--;
        sentCount++;
        firstSent = 1'b1;
        @(posedge clk);
        #DriveDelay;
        blkValid_i = 1'b0;
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        void'($urandom(92));
        clk          = 1'b0;
        rst_i        = 1'b1;
        blkValid_i   = 1'b0;
        src_i        = '0;
        pred_i       = '0;
        dcSet_i      = '0;
        acSet_i      = '0;
        outCredit_i  = 1'b0;
        inCredits    = `RECON_IN_DEPTH;
        heldOut      = `RECON_OUT_CREDITS;
        sentCount    = 0;
        outCount     = 0;
        creditPulses = 0;
        cycleCount   = 0;
        checkCount   = 0;
        errorCount   = 0;
        firstSent    = 1'b0;
        buildTable();
        repeat (5) @(posedge clk);
        #DriveDelay;
        rst_i = 1'b0;
        fork
            returnCredits();
        join_none
        // Quiet period before the first block
        repeat (4) @(posedge clk);
        #DriveDelay;
        for (int n = 0; n < NumTests; n++) begin
            if (n == 0 || testTable[n].dcSet != dcSet_i || testTable[n].acSet != acSet_i) begin
                // Quantizer inputs are shared, so drain before changing them
                while (outCount != sentCount) begin
                    @(posedge clk);
                    #DriveDelay;
                end
                dcSet_i = testTable[n].dcSet;
                acSet_i = testTable[n].acSet;
            end
            sendBlock(n);
        end
        while (outCount < NumTests) begin
            @(posedge clk);
            #DriveDelay;
        end
        repeat (3) @(posedge clk);
        checkCount++;
        if (creditPulses != sentCount) begin
            errorCount++;
            $display("credit_o pulsed %0d times for %0d blocks sent", creditPulses, sentCount);
        end
        $display("Checks %0d, errors %0d, blocks sent %0d, blocks received %0d",
                 checkCount, errorCount, sentCount, outCount);
        if (errorCount == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(WatchdogCycles * ClkPeriod);
        $display("Timeout after %0d cycles with %0d of %0d blocks received",
                 WatchdogCycles, outCount, NumTests);
        $display("Checks %0d, errors %0d, blocks sent %0d, blocks received %0d",
                 checkCount, errorCount, sentCount, outCount);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/reconstruct.sv
`timescale 1ns/100ps
`default_nettype none
`include "recon_config.svh"

module reconstruct
    import recon_pkg::*;
(
    input  wire            clk,
    input  wire            rst_i,
    input  wire            blkValid_i,
    input  wire pixBlock_t src_i,
    input  wire pixBlock_t pred_i,
    input  wire quantSet_t dcSet_i,
    input  wire quantSet_t acSet_i,
    input  wire            outCredit_i,
    output logic           credit_o,
    output logic           outValid_o,
    output pixBlock_t      recon_o,
    output levelBlock_t    levels_o,
    output logic           nonZero_o
);

    stageLink_if fwdToQuant ();
    stageLink_if quantToInv ();

    // Queue, residual and forward DCT
    fwdTransform fwdStage (
        .clk        (clk),
        .rst_i      (rst_i),
        .blkValid_i (blkValid_i),
        .src_i      (src_i),
        .pred_i     (pred_i),
        .credit_o   (credit_o),
        .link       (fwdToQuant.sender)
    );

    quantizer quantStage (
        .clk     (clk),
        .rst_i   (rst_i),
        .dcSet_i (dcSet_i),
        .acSet_i (acSet_i),
        .inLink  (fwdToQuant.receiver),
        .outLink (quantToInv.sender)
    );

    // Dequantize, inverse DCT and output credits
    invTransform invStage (
        .clk         (clk),
        .rst_i       (rst_i),
        .dcSet_i     (dcSet_i),
        .acSet_i     (acSet_i),
        .inLink      (quantToInv.receiver),
        .outCredit_i (outCredit_i),
        .outValid_o  (outValid_o),
        .recon_o     (recon_o),
        .levels_o    (levels_o),
        .nonZero_o   (nonZero_o)
    );

endmodule

`default_nettype wire

// File: verilog/invTransform.sv
`timescale 1ns/100ps
`default_nettype none
`include "recon_config.svh"

module invTransform
    import recon_pkg::*;
(
    input  wire            clk,
    input  wire            rst_i,
    input  wire quantSet_t dcSet_i,
    input  wire quantSet_t acSet_i,
    stageLink_if.receiver  inLink,
    input  wire            outCredit_i,
    output logic           outValid_o,
    output pixBlock_t      recon_o,
    output levelBlock_t    levels_o,
    output logic           nonZero_o
);

    localparam int OutCredits = `RECON_OUT_CREDITS;
    localparam int CredW = $clog2(OutCredits + 1);

    logic [CredW-1:0] outCred;
    slotState_t       slotState;
    pixBlock_t        reconNext;
    levelBlock_t      levelIn;

    // VP8 fixed-point rotations, cos and sin scaled by 2^16
    function automatic longint mul1(input longint a);
        return ((a * 20091) >>> 16) + a;
    endfunction

    function automatic longint mul2(input longint a);
        return (a * 35468) >>> 16;
    endfunction

    // Dequantize, inverse transform, add prediction, clamp to 8 bits
    function automatic pixBlock_t idctAdd(input coefBlock_t lv, input pixBlock_t prd,
                                          input logic [15:0] qDc, input logic [15:0] qAc);
        longint    c [16];
        longint    tmp [16];
        longint    v [4];
        longint    a;
        longint    b;
        longint    cc;
        longint    dd;
        longint    pix;
        pixBlock_t res;
        for (int k = 0; k < 16; k++) begin
            c[k] = longint'(lv[k]) * longint'((k == 0) ? qDc : qAc);
        end
        // Vertical pass
        for (int i = 0; i < 4; i++) begin
            a  = c[i] + c[8+i];
            b  = c[i] - c[8+i];
            cc = mul2(c[4+i]) - mul1(c[12+i]);
            dd = mul1(c[4+i]) + mul2(c[12+i]);
            tmp[4*i]   = a + dd;
            tmp[4*i+1] = b + cc;
            tmp[4*i+2] = b - cc;
            tmp[4*i+3] = a - dd;
        end
        // Horizontal pass, rounding folded into the DC term
        for (int i = 0; i < 4; i++) begin
            a  = tmp[i] + 4 + tmp[8+i];
            b  = tmp[i] + 4 - tmp[8+i];
            cc = mul2(tmp[4+i]) - mul1(tmp[12+i]);
            dd = mul1(tmp[4+i]) + mul2(tmp[12+i]);
            v[0] = a + dd;
            v[1] = b + cc;
            v[2] = b - cc;
            v[3] = a - dd;
            for (int x = 0; x < 4; x++) begin
                pix = longint'(prd[4*i+x]) + (v[x] >>> 3);
                if (pix < 0) begin
                    res[4*i+x] = '0;
                end else if (pix > 255) begin
                    res[4*i+x] = '1;
                end else begin
                    res[4*i+x] = pix_t'(pix);
                end
            end
        end
        return res;
    endfunction

    assign reconNext = idctAdd(inLink.coef, inLink.pred, dcSet_i.q, acSet_i.q);

    always_comb begin
        for (int k = 0; k < 16; k++) begin
            levelIn[k] = level_t'(inLink.coef[k]);
        end
    end

    // ----------------------------------------
    // Output slot and credits
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (inLink.valid) begin
            recon_o   <= reconNext;
            levels_o  <= levelIn;
            nonZero_o <= inLink.nonZero;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            slotState <= slotEmpty;
            outCred   <= CredW'(OutCredits);
        end else begin
            if (inLink.valid) begin
                slotState <= slotFull;
            end else if (outValid_o) begin
                slotState <= slotEmpty;
            end
            outCred <= outCred + CredW'(outCredit_i) - CredW'(outValid_o);
        end
    end

    assign outValid_o    = (slotState == slotFull) && (outCred != '0);
    assign inLink.credit = outValid_o;

    // Receiver returns no more credits than it was given
    assert property (@(posedge clk) disable iff (rst_i)
        outCred <= CredW'(OutCredits));

    // Spending the last credit stalls the output
    assert property (@(posedge clk) disable iff (rst_i)
        outValid_o && outCred == CredW'(1) && !outCredit_i |=> !outValid_o);

endmodule

`default_nettype wire

// File: verilog/quantizer.sv
`timescale 1ns/100ps
`default_nettype none
`include "recon_config.svh"

module quantizer
    import recon_pkg::*;
(
    input  wire            clk,
    input  wire            rst_i,
    input  wire quantSet_t dcSet_i,
    input  wire quantSet_t acSet_i,
    stageLink_if.receiver  inLink,
    stageLink_if.sender    outLink
);

    localparam int CoefW = `RECON_COEF_W;
    localparam int MaxLevel = `RECON_MAX_LEVEL;
    localparam int QShift = `RECON_QSHIFT;
    localparam logic [31:0] BiasOne = 32'(1 << QShift);

    levelBlock_t levelNext;
    coefBlock_t  levelReg;
    pixBlock_t   predReg;
    logic        nzReg;
    logic        sendNow;
    logic        linkCred;
    slotState_t  slotState;

    // Magnitude times iq plus bias, shifted, limited, sign restored
    function automatic level_t quantOne(input coef_t c, input quantSet_t s);
        logic [CoefW-1:0] mag;
        logic [47:0]      acc;
        logic [47:0]      lvl;
        level_t           lim;
        mag = c[CoefW-1] ? -c : c;
        acc = 48'(mag) * 48'(s.iq) + 48'(s.bias);
        lvl = acc >> QShift;
        lim = (lvl > 48'(MaxLevel)) ? level_t'(MaxLevel) : level_t'(lvl);
        return c[CoefW-1] ? -lim : lim;
    endfunction

    always_comb begin
        for (int k = 0; k < 16; k++) begin
            levelNext[k] = quantOne(inLink.coef[k], (k == 0) ? dcSet_i : acSet_i);
        end
    end

    // ----------------------------------------
    // Output slot
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (inLink.valid) begin
            for (int k = 0; k < 16; k++) begin
                levelReg[k] <= coef_t'(levelNext[k]);
            end
            predReg <= inLink.pred;
            nzReg   <= |levelNext;
        end
    end

    assign sendNow = (slotState == slotFull) && linkCred;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            slotState <= slotEmpty;
            linkCred  <= 1'b1;
        end else begin
            if (inLink.valid) begin
                slotState <= slotFull;
            end else if (sendNow) begin
                slotState <= slotEmpty;
            end
            linkCred <= (linkCred && !sendNow) || outLink.credit;
        end
    end

    // Slot frees when the block moves on
    assign inLink.credit   = sendNow;
    assign outLink.valid   = sendNow;
    assign outLink.coef    = levelReg;
    assign outLink.pred    = predReg;
    assign outLink.nonZero = nzReg;

    for (genvar g = 0; g < 16; g++) begin : gLevelChk
        assert property (@(posedge clk) disable iff (rst_i)
            slotState == slotFull |->
                (levelReg[g] <= MaxLevel) && (levelReg[g] >= -MaxLevel));
    end

    // An all-zero residual with small biases yields no levels
    assert property (@(posedge clk) disable iff (rst_i)
        inLink.valid && !inLink.nonZero &&
        dcSet_i.bias < BiasOne && acSet_i.bias < BiasOne |=> !outLink.nonZero);

endmodule

`default_nettype wire

// File: verilog/fwdTransform.sv
`timescale 1ns/100ps
`default_nettype none
`include "recon_config.svh"

module fwdTransform
    import recon_pkg::*;
(
    input  wire         clk,
    input  wire         rst_i,
    input  wire         blkValid_i,
    input  wire pixBlock_t src_i,
    input  wire pixBlock_t pred_i,
    output logic        credit_o,
    stageLink_if.sender link
);

    localparam int Depth = `RECON_IN_DEPTH;
    localparam int PtrW = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int CntW = PtrW + 1;

    pixBlock_t       srcQ [Depth];
    pixBlock_t       predQ [Depth];
    logic [PtrW-1:0] wrPtr;
    logic [PtrW-1:0] rdPtr;
    logic [CntW-1:0] qCount;
    logic            pop;
    logic            sendNow;
    logic            linkCred;
    slotState_t      slotState;
    coefBlock_t      headCoef;
    coefBlock_t      coefReg;
    pixBlock_t       predReg;
    logic            nzReg;

    // VP8 forward DCT of src - prd, rows then columns
    function automatic coefBlock_t fdct(input pixBlock_t src, input pixBlock_t prd);
        int d [16];
        int tmp [16];
        int a0;
        int a1;
        int a2;
        int a3;
        coefBlock_t res;
        for (int k = 0; k < 16; k++) begin
            d[k] = int'(src[k]) - int'(prd[k]);
        end
        for (int r = 0; r < 4; r++) begin
            a0 = d[4*r] + d[4*r+3];
            a1 = d[4*r+1] + d[4*r+2];
            a2 = d[4*r+1] - d[4*r+2];
            a3 = d[4*r] - d[4*r+3];
            tmp[4*r]   = (a0 + a1) * 8;
            tmp[4*r+1] = (a2 * 2217 + a3 * 5352 + 1812) >>> 9;
            tmp[4*r+2] = (a0 - a1) * 8;
            tmp[4*r+3] = (a3 * 2217 - a2 * 5352 + 937) >>> 9;
        end
        for (int c = 0; c < 4; c++) begin
            a0 = tmp[c] + tmp[12+c];
            a1 = tmp[4+c] + tmp[8+c];
            a2 = tmp[4+c] - tmp[8+c];
            a3 = tmp[c] - tmp[12+c];
            res[c]    = coef_t'((a0 + a1 + 7) >>> 4);
            res[4+c]  = coef_t'(((a2 * 2217 + a3 * 5352 + 12000) >>> 16) + int'(a3 != 0));
            res[8+c]  = coef_t'((a0 - a1 + 7) >>> 4);
            res[12+c] = coef_t'((a3 * 2217 - a2 * 5352 + 51000) >>> 16);
        end
        return res;
    endfunction

    // ----------------------------------------
    // Input queue
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (blkValid_i) begin
            srcQ[wrPtr]  <= src_i;
            predQ[wrPtr] <= pred_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wrPtr  <= '0;
            rdPtr  <= '0;
            qCount <= '0;
        end else begin
            if (blkValid_i) begin
                wrPtr <= (wrPtr == PtrW'(Depth - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == PtrW'(Depth - 1)) ? '0 : rdPtr + 1'b1;
            end
            qCount <= qCount + CntW'(blkValid_i) - CntW'(pop);
        end
    end

    // Slot refills in the same cycle it is handed on
    assign sendNow  = (slotState == slotFull) && linkCred;
    assign pop      = (qCount != '0) && ((slotState == slotEmpty) || sendNow);
    assign credit_o = pop;
    assign headCoef = fdct(srcQ[rdPtr], predQ[rdPtr]);

    // ----------------------------------------
    // Output slot
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (pop) begin
            coefReg <= headCoef;
            predReg <= predQ[rdPtr];
            nzReg   <= |headCoef;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            slotState <= slotEmpty;
            linkCred  <= 1'b1;
        end else begin
            if (pop) begin
                slotState <= slotFull;
            end else if (sendNow) begin
                slotState <= slotEmpty;
            end
            // Quantizer holds one block, so one credit is enough
            linkCred <= (linkCred && !sendNow) || link.credit;
        end
    end

    assign link.valid   = sendNow;
    assign link.coef    = coefReg;
    assign link.pred    = predReg;
    assign link.nonZero = nzReg;

    // Upstream sender never pushes into a full queue
    assert property (@(posedge clk) disable iff (rst_i)
        blkValid_i && !pop |-> qCount < CntW'(Depth));

    // No second transfer before the quantizer hands a credit back
    assert property (@(posedge clk) disable iff (rst_i)
        link.valid && !link.credit |=> !link.valid);

endmodule

`default_nettype wire

// File: verilog/stageLink_if.sv
`timescale 1ns/100ps
`default_nettype none

interface stageLink_if
    import recon_pkg::*;
();

    logic       valid;
    // Levels also travel here, sign extended to coefficient width
    coefBlock_t coef;
    pixBlock_t  pred;
    logic       nonZero;
    // Pulsed by the receiver when its slot frees up
    logic       credit;

    modport sender (
        output valid,
        output coef,
        output pred,
        output nonZero,
        input  credit
    );

    modport receiver (
        input  valid,
        input  coef,
        input  pred,
        input  nonZero,
        output credit
    );

endinterface

`default_nettype wire

// File: verilog/recon_pkg.sv
`default_nettype none
`include "recon_config.svh"

package recon_pkg;

    typedef logic [`RECON_PIX_W-1:0] pix_t;
    typedef logic signed [`RECON_COEF_W-1:0] coef_t;
    typedef logic signed [`RECON_LEVEL_W-1:0] level_t;

    // ----------------------------------------
    // 4x4 blocks
    // ----------------------------------------
    // Raster order, element 0 top-left, element 3 top-right
    typedef pix_t [15:0] pixBlock_t;
    // Element 0 is the DC term
    typedef coef_t [15:0] coefBlock_t;
    typedef level_t [15:0] levelBlock_t;

    // One coefficient class of the quantizer matrix
    typedef struct packed {
        logic [15:0] q;
        logic [15:0] iq;
        logic [31:0] bias;
    } quantSet_t;

    // Occupancy of a stage output register
    typedef enum logic {
        slotEmpty = 1'b0,
        slotFull  = 1'b1
    } slotState_t;

endpackage

`default_nettype wire

// File: verilog/recon_config.svh
`ifndef RECON_CONFIG_SVH
`define RECON_CONFIG_SVH

// Datapath widths
`define RECON_PIX_W        8
`define RECON_COEF_W       16
`define RECON_LEVEL_W      16

// Input queue depth, also the sender's starting credit count
`define RECON_IN_DEPTH     2

// Credits held at reset on the output side
`define RECON_OUT_CREDITS  2

// Quantizer
`define RECON_MAX_LEVEL    2047
`define RECON_QSHIFT       17

`endif
